//--- sim/int_pipe_golden.txt
// pc instr valid rd_wr_req rd_addr rd_data redirect pc_new illegal
// All values hex, one instruction per line in fetch order
00000000 00500093 1 1 01 00000005 0 00000004 0  // addi x1, x0, 5
00000004 ffd00113 1 1 02 fffffffd 0 00000008 0  // addi x2, x0, -3
00000008 002081b3 1 1 03 00000002 0 0000000c 0  // add x3, x1, x2
0000000c 40208233 1 1 04 00000008 0 00000010 0  // sub x4, x1, x2
00000010 0041c2b3 1 1 05 0000000a 0 00000014 0  // xor x5, x3, x4
00000014 0020e333 1 1 06 fffffffd 0 00000018 0  // or x6, x1, x2
00000018 0f017393 1 1 07 000000f0 0 0000001c 0  // andi x7, x2, 0xf0
0000001c 01c09413 1 1 08 50000000 0 00000020 0  // slli x8, x1, 28
00000020 40115493 1 1 09 fffffffe 0 00000024 0  // srai x9, x2, 1
00000024 01c15513 1 1 0a 0000000f 0 00000028 0  // srli x10, x2, 28
00000028 001125b3 1 1 0b 00000001 0 0000002c 0  // slt x11, x2, x1
0000002c 00113633 1 1 0c 00000000 0 00000030 0  // sltu x12, x2, x1
00000030 800006b7 1 1 0d 80000000 0 00000034 0  // lui x13, 0x80000
00000034 00001717 1 1 0e 00001034 0 00000038 0  // auipc x14, 0x1
00000038 00708013 1 1 00 0000000c 0 0000003c 0  // addi x0, x1, 7
0000003c 001007b3 1 1 0f 00000005 0 00000040 0  // add x15, x0, x1
00000040 00f08863 1 0 00 00000000 1 00000050 0  // beq x1, x15, +16
00000044 00100a13 0 0 00 00000000 0 00000000 0  // addi x20, x0, 1 (squashed)
00000050 00f09463 1 0 00 00000000 0 00000054 0  // bne x1, x15, +8
00000054 0016c663 1 0 00 00000000 1 00000060 0  // blt x13, x1, +12
00000058 00200a93 0 0 00 00000000 0 00000000 0  // addi x21, x0, 2 (squashed)
00000060 0016d463 1 0 00 00000000 0 00000064 0  // bge x13, x1, +8
00000064 0016e463 1 0 00 00000000 0 00000068 0  // bltu x13, x1, +8
00000068 0016f663 1 0 00 00000000 1 00000074 0  // bgeu x13, x1, +12
0000006c 00300b13 0 0 00 00000000 0 00000000 0  // addi x22, x0, 3 (squashed)
00000074 00c0086f 1 1 10 00000078 1 00000080 0  // jal x16, +12
00000078 00400b93 0 0 00 00000000 0 00000000 0  // addi x23, x0, 4 (squashed)
00000080 09c088e7 1 1 11 00000084 1 000000a0 0  // jalr x17, 0x9c(x1)
00000084 00500c13 0 0 00 00000000 0 00000000 0  // addi x24, x0, 5 (squashed)
000000a0 0000080b 1 0 00 00000000 0 000000a4 1  // custom-0 opcode, rd x16
000000a4 01180933 1 1 12 000000fc 0 000000a8 0  // add x18, x16, x17

//--- flist.f
verilog/core_isa_pkg.sv
verilog/core_pipe_pkg.sv
verilog/decode.sv
verilog/execute.sv
verilog/writeback.sv
verilog/int_pipe_top.sv
sim/int_pipe_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the integer pipeline testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module int_pipe_tb -f flist.f

# A failed check ends the binary with a nonzero status, the search below decides
sim_out=$(./obj_dir/Vint_pipe_tb 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -q "Everything OK"; then
    exit 0
fi
exit 1

//--- sim/int_pipe_tb.sv
// Integer pipeline slice testbench
`timescale 1ns/10ps

module int_pipe_tb
    import core_isa_pkg::*;
    import core_pipe_pkg::*;
();

    localparam int CLK_HALF      = 20;
    localparam int COLS          = 9;
    localparam int MAX_LINES     = 64;
    localparam int RESET_TIMEOUT = 10;
    localparam int DRAIN_TIMEOUT = 8;

    // Golden file columns
    localparam int COL_PC    = 0;
    localparam int COL_INSTR = 1;
    localparam int COL_VALID = 2;
    localparam int COL_WR    = 3;
    localparam int COL_RD    = 4;
    localparam int COL_DATA  = 5;
    localparam int COL_REDIR = 6;
    localparam int COL_PCNEW = 7;
    localparam int COL_ILL   = 8;

    logic         clk;
    logic         reset_i;
    type_fetch_s  fetch_i;
    type_exe2wb_s result_o;

    logic [31:0] golden_mem [COLS*MAX_LINES];
    int          num_lines;
    int          line_idx;
    int          checked;
    int          wait_cycles;

    int_pipe_top #(
        .NUM_REGS(32)
    ) i_int_pipe_top (
        .clk      (clk),
        .reset_i  (reset_i),
        .fetch_i  (fetch_i),
        .result_o (result_o)
    );

    always #CLK_HALF clk = ~clk;

    // Marker for words the file did not overwrite
    function automatic logic [31:0] fill_word(int addr);
        return 32'hA5A5_0000 + 32'(addr);
    endfunction

    function automatic logic [31:0] golden_word(int n, int col);
        return golden_mem[n*COLS + col];
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR at %0d ns: %s expected %h, actual %h", $time, name, expected, actual);
            $display("Something failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out after %0d cycles waiting for %s", wait_cycles, what);
        $display("Something failed");
        $fatal(1, "Timeout");
    endtask

    task automatic load_golden();
        int a;
        for (a = 0; a < COLS*MAX_LINES; a++) begin
            golden_mem[a] = fill_word(a);
        end
        $readmemh("sim/int_pipe_golden.txt", golden_mem);
        // Lines end where the pc column still holds the marker
        num_lines = 0;
        while ((num_lines < MAX_LINES)
               && (golden_mem[num_lines*COLS] != fill_word(num_lines*COLS))) begin
            num_lines++;
        end
        if (num_lines < 3) begin
            $display("The golden file holds fewer than three instruction lines");
            $display("Something failed");
            $fatal(1, "No usable stimulus");
        end
    endtask

    // Nothing may come out before the first instruction arrives
    task automatic check_idle();
        check_value("result_o.valid", 32'h0, 32'(result_o.valid));
        check_value("result_o.redirect", 32'h0, 32'(result_o.redirect));
        check_value("result_o.illegal", 32'h0, 32'(result_o.illegal));
    endtask

    task automatic check_line(input int n);
        check_value("result_o.valid", golden_word(n, COL_VALID), 32'(result_o.valid));
        check_value("result_o.rd_wr_req", golden_word(n, COL_WR), 32'(result_o.rd_wr_req));
        check_value("result_o.redirect", golden_word(n, COL_REDIR), 32'(result_o.redirect));
        check_value("result_o.illegal", golden_word(n, COL_ILL), 32'(result_o.illegal));
        // Squashed slots carry no meaningful target
        if (golden_word(n, COL_VALID) != 32'h0) begin
            check_value("result_o.pc_new", golden_word(n, COL_PCNEW), result_o.pc_new);
        end
        // Destination only matters when a write is requested
        if (golden_word(n, COL_WR) != 32'h0) begin
            check_value("result_o.rd_addr", golden_word(n, COL_RD), 32'(result_o.rd_addr));
            check_value("result_o.rd_data", golden_word(n, COL_DATA), result_o.rd_data);
        end
        checked++;
    endtask

    task automatic drive_line(input int n);
        fetch_i.valid <= 1'b1;
        fetch_i.pc    <= golden_word(n, COL_PC);
        fetch_i.instr <= golden_word(n, COL_INSTR);
    endtask

    initial begin
        clk     = 1'b0;
        reset_i <= 1'b1;
        fetch_i <= '0;
        checked = 0;
        load_golden();

        repeat (2) @(posedge clk);
        reset_i <= 1'b0;

        wait_cycles = 0;
        while (reset_i === 1'b1) begin
            @(negedge clk);
            wait_cycles++;
            if (wait_cycles > RESET_TIMEOUT) begin
                report_timeout("reset release");
            end
        end
        check_idle();

        // Result of line n shows up two edges after line n is driven
        for (line_idx = 0; line_idx < num_lines; line_idx++) begin
            @(posedge clk);
            drive_line(line_idx);
            @(negedge clk);
            if (line_idx >= 2) begin
                check_line(line_idx - 2);
            end else begin
                check_idle();
            end
        end

        // Drain the two instructions still in flight
        wait_cycles = 0;
        while (checked < num_lines) begin
            @(posedge clk);
            fetch_i <= '0;
            @(negedge clk);
            check_line(checked);
            wait_cycles++;
            if ((checked < num_lines) && (wait_cycles > DRAIN_TIMEOUT)) begin
                report_timeout("the pipeline to drain");
            end
        end

        $display("Everything OK");
        $finish;
    end

endmodule

//--- verilog/int_pipe_top.sv
// Integer pipeline slice top level
`timescale 1ns/10ps

module int_pipe_top
    import core_isa_pkg::*;
    import core_pipe_pkg::*;
#(
    parameter int NUM_REGS = 32
) (
    input  logic         clk,
    input  logic         reset_i,
    input  type_fetch_s  fetch_i,
    output type_exe2wb_s result_o
);

    type_id2exe_ctrl_s    id2exe_ctrl;
    type_id2exe_data_s    id2exe_data;
    type_exe2fwd_s        exe2fwd;
    type_fwd2exe_s        fwd2exe;
    logic                 flush;
    logic [RF_AWIDTH-1:0] rs1_addr;
    logic [RF_AWIDTH-1:0] rs2_addr;
    logic [XLEN-1:0]      rs1_data;
    logic [XLEN-1:0]      rs2_data;

    decode #(
        .NUM_REGS(NUM_REGS)
    ) i_decode (
        .clk           (clk),
        .reset_i       (reset_i),
        .fetch_i       (fetch_i),
        .flush_i       (flush),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .id2exe_ctrl_o (id2exe_ctrl),
        .id2exe_data_o (id2exe_data)
    );

    execute i_execute (
        .clk           (clk),
        .reset_i       (reset_i),
        .id2exe_ctrl_i (id2exe_ctrl),
        .id2exe_data_i (id2exe_data),
        .fwd2exe_i     (fwd2exe),
        .exe2fwd_o     (exe2fwd),
        .flush_o       (flush),
        .exe2wb_o      (result_o)
    );

    // Execute result register feeds writeback and the output alike
    writeback #(
        .NUM_REGS(NUM_REGS)
    ) i_writeback (
        .clk        (clk),
        .reset_i    (reset_i),
        .exe2wb_i   (result_o),
        .exe2fwd_i  (exe2fwd),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .fwd2exe_o  (fwd2exe)
    );

endmodule

//--- verilog/writeback.sv
// Register file and result writeback
`timescale 1ns/10ps

module writeback
    import core_isa_pkg::*;
    import core_pipe_pkg::*;
#(
    parameter int NUM_REGS = 32
) (
    input  logic                 clk,
    input  logic                 reset_i,
    input  type_exe2wb_s         exe2wb_i,
    input  type_exe2fwd_s        exe2fwd_i,
    input  logic [RF_AWIDTH-1:0] rs1_addr_i,
    input  logic [RF_AWIDTH-1:0] rs2_addr_i,
    output logic [XLEN-1:0]      rs1_data_o,
    output logic [XLEN-1:0]      rs2_data_o,
    output type_fwd2exe_s        fwd2exe_o
);

    logic [XLEN-1:0] reg_file [NUM_REGS];
    logic            wr_en;

    // x0 reads zero, a write in flight is passed straight through
    function automatic logic [XLEN-1:0] read_port(logic [RF_AWIDTH-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (wr_en && (addr == exe2wb_i.rd_addr)) begin
            return exe2wb_i.rd_data;
        end
        return reg_file[addr];
    endfunction

    // Valid result with a nonzero destination
    assign wr_en = exe2wb_i.valid && exe2wb_i.rd_wr_req && (exe2wb_i.rd_addr != '0);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                reg_file[i] <= '0;
            end
        end else if (wr_en) begin
            reg_file[exe2wb_i.rd_addr] <= exe2wb_i.rd_data;
        end
    end

    // Decode read ports, distance-two bypass included
    always_comb begin
        rs1_data_o = read_port(rs1_addr_i);
        rs2_data_o = read_port(rs2_addr_i);
    end

    // Distance-one forwarding into execute
    always_comb begin
        fwd2exe_o.fwd_wrb_rs1 = wr_en && exe2fwd_i.use_rs1
                              && (exe2wb_i.rd_addr == exe2fwd_i.rs1_addr);
        fwd2exe_o.fwd_wrb_rs2 = wr_en && exe2fwd_i.use_rs2
                              && (exe2wb_i.rd_addr == exe2fwd_i.rs2_addr);
        fwd2exe_o.fwd_data    = exe2wb_i.rd_data;
    end

    // Decode marks out-of-range destinations illegal, so none reach here
    assert property (@(posedge clk) disable iff (reset_i)
        wr_en |-> (int'(exe2wb_i.rd_addr) < NUM_REGS));

endmodule

//--- verilog/execute.sv
// Execute stage with ALU and branch unit
`timescale 1ns/10ps

module execute
    import core_isa_pkg::*;
    import core_pipe_pkg::*;
(
    input  logic              clk,
    input  logic              reset_i,
    input  type_id2exe_ctrl_s id2exe_ctrl_i,
    input  type_id2exe_data_s id2exe_data_i,
    input  type_fwd2exe_s     fwd2exe_i,
    output type_exe2fwd_s     exe2fwd_o,
    output logic              flush_o,
    output type_exe2wb_s      exe2wb_o
);

    logic [XLEN-1:0]         operand_rs1;
    logic [XLEN-1:0]         operand_rs2;
    logic [XLEN-1:0]         alu_operand_1;
    logic [XLEN-1:0]         alu_operand_2;
    logic [XLEN-1:0]         alu_adder;
    logic [XLEN-1:0]         alu_result;
    logic [$clog2(XLEN)-1:0] shift_amt;
    logic [XLEN-1:0]         cmp_operand_2;
    logic [XLEN:0]           cmp_output;
    logic                    cmp_zero;
    logic                    cmp_neg;
    logic                    cmp_overflow;
    logic                    is_branch;
    logic                    branch_res;
    logic                    taken;
    logic [XLEN-1:0]         target;
    type_exe2wb_s            exe2wb_d;

    // Result of the previous instruction wins over stale read data
    assign operand_rs1 = fwd2exe_i.fwd_wrb_rs1 ? fwd2exe_i.fwd_data : id2exe_data_i.rs1_data;
    assign operand_rs2 = fwd2exe_i.fwd_wrb_rs2 ? fwd2exe_i.fwd_data : id2exe_data_i.rs2_data;

    assign alu_operand_1 = (id2exe_ctrl_i.opr1_sel == OPR1_SEL_PC) ? id2exe_data_i.pc
                                                                   : operand_rs1;
    assign alu_operand_2 = (id2exe_ctrl_i.opr2_sel == OPR2_SEL_IMM) ? id2exe_data_i.imm
                                                                    : operand_rs2;

    assign shift_amt = alu_operand_2[$clog2(XLEN)-1:0];
    assign alu_adder = (id2exe_ctrl_i.alu_ops == ALU_OPS_SUB) ? alu_operand_1 - alu_operand_2
                                                              : alu_operand_1 + alu_operand_2;

    // Comparator; branches compare rs2, SLT/SLTU compare operand 2
    assign is_branch     = (id2exe_ctrl_i.br_ops != BR_OPS_NONE);
    assign cmp_operand_2 = is_branch ? operand_rs2 : alu_operand_2;
    assign cmp_output    = {1'b0, operand_rs1} - {1'b0, cmp_operand_2};
    assign cmp_zero      = (cmp_output[XLEN-1:0] == '0);
    assign cmp_neg       = cmp_output[XLEN-1];
    // Signed overflow when the operand signs differ and the result sign flips
    assign cmp_overflow  = (operand_rs1[XLEN-1] ^ cmp_operand_2[XLEN-1])
                         & (operand_rs1[XLEN-1] ^ cmp_neg);

    always_comb begin
        case (id2exe_ctrl_i.br_ops)
            BR_OPS_EQ:  branch_res = cmp_zero;
            BR_OPS_NE:  branch_res = ~cmp_zero;
            BR_OPS_LT:  branch_res = cmp_neg ^ cmp_overflow;
            BR_OPS_GE:  branch_res = ~(cmp_neg ^ cmp_overflow);
            // Bit XLEN is the borrow out, set when rs1 < rs2 unsigned
            BR_OPS_LTU: branch_res = cmp_output[XLEN];
            BR_OPS_GEU: branch_res = ~cmp_output[XLEN];
            default:    branch_res = 1'b0;
        endcase
    end

    always_comb begin
        case (id2exe_ctrl_i.alu_ops)
            ALU_OPS_ADD,
            ALU_OPS_SUB:       alu_result = alu_adder;
            ALU_OPS_SLL:       alu_result = alu_operand_1 << shift_amt;
            ALU_OPS_SLT:       alu_result = XLEN'(cmp_neg ^ cmp_overflow);
            ALU_OPS_SLTU:      alu_result = XLEN'(cmp_output[XLEN]);
            ALU_OPS_XOR:       alu_result = alu_operand_1 ^ alu_operand_2;
            ALU_OPS_SRL:       alu_result = alu_operand_1 >> shift_amt;
            ALU_OPS_SRA:       alu_result = $signed(alu_operand_1) >>> shift_amt;
            ALU_OPS_OR:        alu_result = alu_operand_1 | alu_operand_2;
            ALU_OPS_AND:       alu_result = alu_operand_1 & alu_operand_2;
            ALU_OPS_COPY_OPR2: alu_result = alu_operand_2;
            default:           alu_result = '0;
        endcase
    end

    // Jump and branch target from the adder, JALR drops bit 0
    assign target = {alu_adder[XLEN-1:1], alu_adder[0] & ~id2exe_ctrl_i.jalr_req};
    assign taken  = id2exe_ctrl_i.valid & ~id2exe_ctrl_i.illegal
                  & (id2exe_ctrl_i.jump_req | branch_res);

    // Squashes the younger instruction sitting in decode
    assign flush_o = taken;

    // Sources for the forwarding compare in writeback
    assign exe2fwd_o.rs1_addr = id2exe_data_i.rs1_addr;
    assign exe2fwd_o.rs2_addr = id2exe_data_i.rs2_addr;
    assign exe2fwd_o.use_rs1  = id2exe_ctrl_i.valid
                              & ((id2exe_ctrl_i.opr1_sel == OPR1_SEL_REG) | is_branch);
    assign exe2fwd_o.use_rs2  = id2exe_ctrl_i.valid
                              & ((id2exe_ctrl_i.opr2_sel == OPR2_SEL_REG) | is_branch);

    always_comb begin
        exe2wb_d.valid     = id2exe_ctrl_i.valid;
        exe2wb_d.rd_wr_req = id2exe_ctrl_i.valid & id2exe_ctrl_i.rd_wr_req;
        exe2wb_d.rd_addr   = id2exe_data_i.rd_addr;
        // Link address for jumps
        exe2wb_d.rd_data   = id2exe_ctrl_i.jump_req ? id2exe_data_i.pc_next : alu_result;
        exe2wb_d.redirect  = taken;
        exe2wb_d.pc_new    = taken ? target : id2exe_data_i.pc_next;
        exe2wb_d.illegal   = id2exe_ctrl_i.valid & id2exe_ctrl_i.illegal;
    end

    // Execute pipeline register, reset clears only the control bits
    always_ff @(posedge clk) begin
        exe2wb_o <= exe2wb_d;
        if (reset_i) begin
            exe2wb_o.valid     <= 1'b0;
            exe2wb_o.rd_wr_req <= 1'b0;
            exe2wb_o.redirect  <= 1'b0;
            exe2wb_o.illegal   <= 1'b0;
        end
    end

    // Writeback only forwards into a source this instruction reads
    assert property (@(posedge clk) disable iff (reset_i)
        fwd2exe_i.fwd_wrb_rs1 |-> exe2fwd_o.use_rs1);
    assert property (@(posedge clk) disable iff (reset_i)
        fwd2exe_i.fwd_wrb_rs2 |-> exe2fwd_o.use_rs2);

endmodule

//--- verilog/decode.sv
// Instruction decode stage
`timescale 1ns/10ps

module decode
    import core_isa_pkg::*;
    import core_pipe_pkg::*;
#(
    parameter int NUM_REGS = 32
) (
    input  logic                 clk,
    input  logic                 reset_i,
    input  type_fetch_s          fetch_i,
    input  logic                 flush_i,
    input  logic [XLEN-1:0]      rs1_data_i,
    input  logic [XLEN-1:0]      rs2_data_i,
    output logic [RF_AWIDTH-1:0] rs1_addr_o,
    output logic [RF_AWIDTH-1:0] rs2_addr_o,
    output type_id2exe_ctrl_s    id2exe_ctrl_o,
    output type_id2exe_data_s    id2exe_data_o
);

    type_instr_u       instr;
    type_id2exe_ctrl_s ctrl;
    type_id2exe_data_s data;
    logic              use_rs1;
    logic              use_rs2;
    logic              bad_reg;

    // True for an index beyond the implemented registers (RV32E)
    function automatic logic reg_invalid(logic [RF_AWIDTH-1:0] addr);
        return int'(addr) >= NUM_REGS;
    endfunction

    // Maps funct3 to an ALU operation
    // alt is funct7 bit 5 and gives SUB only for OP
    function automatic type_alu_ops_e alu_decode(logic [2:0] funct3, logic alt, logic is_op);
        case (funct3)
            3'b000:  return (alt && is_op) ? ALU_OPS_SUB : ALU_OPS_ADD;
            3'b001:  return ALU_OPS_SLL;
            3'b010:  return ALU_OPS_SLT;
            3'b011:  return ALU_OPS_SLTU;
            3'b100:  return ALU_OPS_XOR;
            3'b101:  return alt ? ALU_OPS_SRA : ALU_OPS_SRL;
            3'b110:  return ALU_OPS_OR;
            default: return ALU_OPS_AND;
        endcase
    endfunction

    // Maps funct3 to a branch condition
    // NONE marks a reserved encoding
    function automatic type_br_ops_e br_decode(logic [2:0] funct3);
        case (funct3)
            3'b000:  return BR_OPS_EQ;
            3'b001:  return BR_OPS_NE;
            3'b100:  return BR_OPS_LT;
            3'b101:  return BR_OPS_GE;
            3'b110:  return BR_OPS_LTU;
            3'b111:  return BR_OPS_GEU;
            default: return BR_OPS_NONE;
        endcase
    endfunction

    assign instr = fetch_i.instr;

    // Register file read addresses sit at fixed positions in every format
    assign rs1_addr_o = instr.r_type.rs1;
    assign rs2_addr_o = instr.r_type.rs2;

    always_comb begin
        // Defaults describe an ADD with rs1 and the I immediate
        ctrl          = '0;
        ctrl.valid    = fetch_i.valid;
        ctrl.alu_ops  = ALU_OPS_ADD;
        ctrl.br_ops   = BR_OPS_NONE;
        ctrl.opr1_sel = OPR1_SEL_REG;
        ctrl.opr2_sel = OPR2_SEL_IMM;
        data.imm      = {{20{instr.i_type.imm[11]}}, instr.i_type.imm};
        case (instr.r_type.opcode)
            OPC_OP: begin
                ctrl.opr2_sel  = OPR2_SEL_REG;
                ctrl.alu_ops   = alu_decode(instr.r_type.funct3, instr.r_type.funct7[5], 1'b1);
                ctrl.rd_wr_req = 1'b1;
            end
            OPC_OP_IMM: begin
                // imm bit 10 is funct7 bit 5 and picks SRAI
                ctrl.alu_ops   = alu_decode(instr.i_type.funct3, instr.i_type.imm[10], 1'b0);
                ctrl.rd_wr_req = 1'b1;
            end
            OPC_LUI, OPC_AUIPC: begin
                ctrl.opr1_sel  = OPR1_SEL_PC;
                ctrl.alu_ops   = (instr.u_type.opcode == OPC_LUI) ? ALU_OPS_COPY_OPR2
                                                                 : ALU_OPS_ADD;
                ctrl.rd_wr_req = 1'b1;
                data.imm       = {instr.u_type.imm_31_12, 12'b0};
            end
            OPC_JAL: begin
                ctrl.opr1_sel  = OPR1_SEL_PC;
                ctrl.jump_req  = 1'b1;
                ctrl.rd_wr_req = 1'b1;
                data.imm       = {{11{instr.j_type.imm_20}}, instr.j_type.imm_20,
                                  instr.j_type.imm_19_12, instr.j_type.imm_11,
                                  instr.j_type.imm_10_1, 1'b0};
            end
            OPC_JALR: begin
                ctrl.jump_req  = 1'b1;
                ctrl.jalr_req  = 1'b1;
                ctrl.rd_wr_req = 1'b1;
            end
            OPC_BRANCH: begin
                // Adder forms pc+imm while the comparator sees rs1 and rs2
                ctrl.opr1_sel = OPR1_SEL_PC;
                ctrl.br_ops   = br_decode(instr.b_type.funct3);
                ctrl.illegal  = (ctrl.br_ops == BR_OPS_NONE);
                data.imm      = {{19{instr.b_type.imm_12}}, instr.b_type.imm_12,
                                 instr.b_type.imm_11, instr.b_type.imm_10_5,
                                 instr.b_type.imm_4_1, 1'b0};
            end
            default: begin
                ctrl.illegal = 1'b1;
            end
        endcase

        // Only registers the instruction really touches are range checked
        use_rs1 = (ctrl.opr1_sel == OPR1_SEL_REG) || (ctrl.br_ops != BR_OPS_NONE);
        use_rs2 = (ctrl.opr2_sel == OPR2_SEL_REG) || (ctrl.br_ops != BR_OPS_NONE);
        bad_reg = (use_rs1 && reg_invalid(instr.r_type.rs1))
                || (use_rs2 && reg_invalid(instr.r_type.rs2))
                || (ctrl.rd_wr_req && reg_invalid(instr.r_type.rd));
        if (ctrl.illegal || bad_reg) begin
            ctrl.illegal   = 1'b1;
            ctrl.rd_wr_req = 1'b0;
        end

        data.pc       = fetch_i.pc;
        data.pc_next  = fetch_i.pc + XLEN'(4);
        data.rs1_data = rs1_data_i;
        data.rs2_data = rs2_data_i;
        data.rs1_addr = instr.r_type.rs1;
        data.rs2_addr = instr.r_type.rs2;
        data.rd_addr  = instr.r_type.rd;
    end

    // A taken redirect squashes the slot in the decode pipeline register
    always_ff @(posedge clk) begin
        if (reset_i) begin
            id2exe_ctrl_o <= '0;
        end else begin
            id2exe_ctrl_o       <= ctrl;
            id2exe_ctrl_o.valid <= ctrl.valid & ~flush_i;
        end
    end

    always_ff @(posedge clk) begin
        id2exe_data_o <= data;
    end

endmodule

//--- verilog/core_pipe_pkg.sv
// Pipeline stage structures
package core_pipe_pkg;
    import core_isa_pkg::*;

    // Instruction from fetch
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } type_fetch_s;

    // Decoded control for execute
    typedef struct packed {
        logic           valid;
        type_alu_ops_e  alu_ops;
        type_br_ops_e   br_ops;
        type_opr1_sel_e opr1_sel;
        type_opr2_sel_e opr2_sel;
        logic           jump_req;
        logic           jalr_req;
        logic           rd_wr_req;
        logic           illegal;
    } type_id2exe_ctrl_s;

    // Decoded data for execute
    typedef struct packed {
        logic [XLEN-1:0]      pc;
        logic [XLEN-1:0]      pc_next;
        logic [XLEN-1:0]      imm;
        logic [XLEN-1:0]      rs1_data;
        logic [XLEN-1:0]      rs2_data;
        logic [RF_AWIDTH-1:0] rs1_addr;
        logic [RF_AWIDTH-1:0] rs2_addr;
        logic [RF_AWIDTH-1:0] rd_addr;
    } type_id2exe_data_s;

    // Source registers of the instruction in execute
    typedef struct packed {
        logic [RF_AWIDTH-1:0] rs1_addr;
        logic [RF_AWIDTH-1:0] rs2_addr;
        logic                 use_rs1;
        logic                 use_rs2;
    } type_exe2fwd_s;

    // Forwarding selects and the value to forward
    typedef struct packed {
        logic            fwd_wrb_rs1;
        logic            fwd_wrb_rs2;
        logic [XLEN-1:0] fwd_data;
    } type_fwd2exe_s;

    // Registered execute result, also the slice output
    typedef struct packed {
        logic                 valid;
        logic                 rd_wr_req;
        logic [RF_AWIDTH-1:0] rd_addr;
        logic [XLEN-1:0]      rd_data;
        logic                 redirect;
        logic [XLEN-1:0]      pc_new;
        logic                 illegal;
    } type_exe2wb_s;

endpackage

//--- verilog/core_isa_pkg.sv
// RV32I ISA definitions
package core_isa_pkg;

    // Data width and register address width
    parameter int XLEN      = 32;
    parameter int RF_AWIDTH = 5;

    // Major opcodes handled by the slice
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } type_opcode_e;

    // ALU operation selects
    typedef enum logic [3:0] {
        ALU_OPS_ADD, ALU_OPS_SUB, ALU_OPS_SLL, ALU_OPS_SLT,
        ALU_OPS_SLTU, ALU_OPS_XOR, ALU_OPS_SRL, ALU_OPS_SRA,
        ALU_OPS_OR, ALU_OPS_AND, ALU_OPS_COPY_OPR2
    } type_alu_ops_e;

    // Branch conditions, NONE for anything that is not a branch
    typedef enum logic [2:0] {
        BR_OPS_NONE, BR_OPS_EQ, BR_OPS_NE, BR_OPS_LT,
        BR_OPS_GE, BR_OPS_LTU, BR_OPS_GEU
    } type_br_ops_e;

    // ALU operand sources
    typedef enum logic {OPR1_SEL_REG, OPR1_SEL_PC} type_opr1_sel_e;
    typedef enum logic {OPR2_SEL_REG, OPR2_SEL_IMM} type_opr2_sel_e;

    // Register-register format
    typedef struct packed {
        logic [6:0]           funct7;
        logic [RF_AWIDTH-1:0] rs2;
        logic [RF_AWIDTH-1:0] rs1;
        logic [2:0]           funct3;
        logic [RF_AWIDTH-1:0] rd;
        type_opcode_e         opcode;
    } type_r_type_s;

    // Immediate format, also JALR
    typedef struct packed {
        logic [11:0]          imm;
        logic [RF_AWIDTH-1:0] rs1;
        logic [2:0]           funct3;
        logic [RF_AWIDTH-1:0] rd;
        type_opcode_e         opcode;
    } type_i_type_s;

    // Store format
    typedef struct packed {
        logic [6:0]           imm_11_5;
        logic [RF_AWIDTH-1:0] rs2;
        logic [RF_AWIDTH-1:0] rs1;
        logic [2:0]           funct3;
        logic [4:0]           imm_4_0;
        type_opcode_e         opcode;
    } type_s_type_s;

    // Branch format, immediate bits scattered
    typedef struct packed {
        logic                 imm_12;
        logic [5:0]           imm_10_5;
        logic [RF_AWIDTH-1:0] rs2;
        logic [RF_AWIDTH-1:0] rs1;
        logic [2:0]           funct3;
        logic [3:0]           imm_4_1;
        logic                 imm_11;
        type_opcode_e         opcode;
    } type_b_type_s;

    // Upper immediate format
    typedef struct packed {
        logic [19:0]          imm_31_12;
        logic [RF_AWIDTH-1:0] rd;
        type_opcode_e         opcode;
    } type_u_type_s;

    // Jump format
    typedef struct packed {
        logic                 imm_20;
        logic [9:0]           imm_10_1;
        logic                 imm_11;
        logic [7:0]           imm_19_12;
        logic [RF_AWIDTH-1:0] rd;
        type_opcode_e         opcode;
    } type_j_type_s;

    // One instruction word, six ways to read it
    typedef union packed {
        type_r_type_s r_type;
        type_i_type_s i_type;
        type_s_type_s s_type;
        type_b_type_s b_type;
        type_u_type_s u_type;
        type_j_type_s j_type;
    } type_instr_u;

endpackage
